/* sources.f */
hw/board_pkg.sv
hw/gpio_regs_pkg.sv
hw/board_reset.sv
hw/pad_input_sync.sv
hw/gpio_regs.sv
hw/pad_output.sv
hw/gpio_board.sv
testbench/tb_gpio_board.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the gpio_board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_gpio_board -f sources.f \
	-o tb_gpio_board_sim > build.log 2>&1 \
	&& ./obj_dir/tb_gpio_board_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || exit 1
exit 0

/* testbench/tb_gpio_board.sv */
`timescale 1ns/10ps

module tb_gpio_board;
	import board_pkg::*;
	import gpio_regs_pkg::*;

	// dpad_l is the only button wired active low
	localparam pad_vec_t low_active_pads = 11'h100;
	// idle pads, every logical level low
	localparam pad_vec_t pads_idle = 11'h100;
	// stretch length of the internal reset in clk_sys cycles
	localparam int hold_cycles = 16;

	logic clk_sys;
	logic rst_n;
	logic reg_wen;
	logic reg_ren;
	reg_addr_t reg_addr;
	reg_data_t reg_wdata;
	reg_data_t reg_rdata;
	pad_vec_t pad_in;
	pad_vec_t pad_out;
	pad_vec_t pad_oe;
	logic [n_leds-1:0] led;
	logic irq;

	int err_count;
	int test_count;
	int tests_failed;
	int test_err_start;
	bit timed_out;
	string cur_test;

	gpio_board gpio_board_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.reg_wen   (reg_wen),
		.reg_ren   (reg_ren),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.pad_in    (pad_in),
		.pad_out   (pad_out),
		.pad_oe    (pad_oe),
		.led       (led),
		.irq       (irq)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic reg_data_t word_of(input pad_vec_t p);
		return {5'b0, p};
	endfunction

	// LED rule of the board, levels already after inversion
	function automatic logic [n_leds-1:0] led_expect(input pad_vec_t lvl, input pad_vec_t outs,
			input pad_vec_t oes);
		logic [n_leds-1:0] v;
		v[6] = ~outs[pin_uart_tx];
		v[5] = ~lvl[pin_uart_rx];
		v[4] = lvl[pin_dpad_u];
		v[3] = lvl[pin_dpad_d];
		v[2] = lvl[pin_dpad_l];
		v[1] = ~lvl[pin_dpad_r];
		v[0] = ~(outs[pin_led] & oes[pin_led]);
		return v;
	endfunction

	task automatic check_data(input string what, input reg_data_t exp, input reg_data_t act);
		if (act !== exp) begin
			$display("FAILED %s, %s: expected %h actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_pads(input string what, input pad_vec_t exp, input pad_vec_t act);
		if (act !== exp) begin
			$display("FAILED %s, %s: expected %h actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_led(input string what, input logic [n_leds-1:0] exp,
			input logic [n_leds-1:0] act);
		if (act !== exp) begin
			$display("FAILED %s, %s: expected %b actual %b", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s, %s: expected %b actual %b", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	// all bus tasks start and end on a falling edge
	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
		end
	endtask

	task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
		reg_wen = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(posedge clk_sys);
		@(negedge clk_sys);
		reg_wen = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
		reg_ren = 1'b1;
		reg_addr = addr;
		@(posedge clk_sys);
		@(negedge clk_sys);
		reg_ren = 1'b0;
		data = reg_rdata;
	endtask

	task automatic wait_reset_release(input int max_cycles, output int waited);
		int n;
		n = 0;
		while (gpio_board_inst.sys_rst_n !== 1'b1 && n < max_cycles) begin
			@(negedge clk_sys);
			n++;
		end
		waited = n;
		if (gpio_board_inst.sys_rst_n !== 1'b1) begin
			$display("timeout: internal reset still held after %0d cycles", max_cycles);
			timed_out = 1'b1;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err_start = err_count;
		test_count++;
	endtask

	task automatic finish_test();
		if (err_count == test_err_start) begin
			$display("%s: pass", cur_test);
		end else begin
			$display("%s: %0d mismatches", cur_test, err_count - test_err_start);
			tests_failed++;
		end
	endtask

	task automatic test_reset();
		reg_data_t rd;
		int waited;
		start_test("reset");
		rst_n = 1'b0;
		wait_cycles(5);
		rst_n = 1'b1;
		// late accesses while the stretcher still holds, the write must be lost
		wait_cycles(12);
		bus_write(reg_out, 16'h07ff);
		bus_read(reg_out, rd);
		if (gpio_board_inst.sys_rst_n !== 1'b0) begin
			$display("%s: internal reset released before the hold time ended", cur_test);
			err_count++;
		end
		check_data("read during hold", 16'h0000, rd);
		wait_reset_release(64, waited);
		if (!timed_out) begin
			// 14 edges with rst_n high went by before the wait
			if (waited + 14 != hold_cycles) begin
				$display("%s: internal reset released after %0d cycles instead of %0d",
					cur_test, waited + 14, hold_cycles);
				err_count++;
			end
			check_pads("pad_out", 11'h000, pad_out);
			check_pads("pad_oe", 11'h000, pad_oe);
			check_bit("irq", 1'b0, irq);
			check_data("reg_rdata", 16'h0000, reg_rdata);
			check_led("led", led_expect(pads_idle ^ low_active_pads, 11'h000, 11'h000), led);
		end
		finish_test();
	endtask

	task automatic test_output_drive();
		reg_data_t rd;
		start_test("output drive");
		// upper bus bits are not part of the register
		bus_write(reg_out, 16'hfda3);
		check_pads("pad_out one edge after write", 11'h000, pad_out);
		wait_cycles(1);
		check_pads("pad_out", 11'h5a3, pad_out);
		bus_write(reg_oe, 16'h03c5);
		check_pads("pad_oe one edge after write", 11'h000, pad_oe);
		wait_cycles(1);
		check_pads("pad_oe", 11'h3c5, pad_oe);
		bus_read(reg_out, rd);
		check_data("reg_out readback", 16'h05a3, rd);
		bus_read(reg_oe, rd);
		check_data("reg_oe readback", 16'h03c5, rd);
		finish_test();
	endtask

	task automatic test_input_conditioning();
		pad_vec_t patterns [4];
		reg_data_t rd;
		patterns = '{11'h000, 11'h7ff, 11'h2a5, 11'h15a};
		start_test("input conditioning");
		foreach (patterns[i]) begin
			pad_in = patterns[i];
			wait_cycles(3);
			bus_read(reg_in, rd);
			check_data($sformatf("reg_in pattern %0d", i),
				word_of(patterns[i] ^ low_active_pads), rd);
		end
		pad_in = pads_idle;
		wait_cycles(3);
		finish_test();
	endtask

	task automatic test_edge_irq();
		reg_data_t rd;
		start_test("edge capture and irq");
		bus_write(reg_irq_en, 16'h0000);
		bus_write(reg_edge, 16'h07ff);
		bus_read(reg_edge, rd);
		check_data("pending before edges", 16'h0000, rd);
		// dpad_u pressed, dpad_l pulled low
		pad_in = 11'h040;
		wait_cycles(3);
		bus_read(reg_edge, rd);
		check_data("pending bits", 16'h0140, rd);
		check_bit("irq while disabled", 1'b0, irq);
		bus_write(reg_irq_en, 16'h0140);
		wait_cycles(1);
		check_bit("irq enabled", 1'b1, irq);
		bus_write(reg_edge, 16'h0140);
		wait_cycles(1);
		check_bit("irq after clear", 1'b0, irq);
		bus_read(reg_edge, rd);
		check_data("pending after clear", 16'h0000, rd);
		bus_write(reg_irq_en, 16'h0000);
		pad_in = pads_idle;
		wait_cycles(3);
		finish_test();
	endtask

	task automatic test_led_mapping();
		pad_vec_t pads [5];
		pad_vec_t outs [5];
		pad_vec_t oes [5];
		pads = '{11'h100, 11'h7ff, 11'h000, 11'h2c2, 11'h0c0};
		outs = '{11'h000, 11'h7ff, 11'h401, 11'h400, 11'h001};
		oes = '{11'h000, 11'h7ff, 11'h400, 11'h000, 11'h401};
		start_test("led mapping");
		foreach (pads[i]) begin
			bus_write(reg_out, word_of(outs[i]));
			bus_write(reg_oe, word_of(oes[i]));
			pad_in = pads[i];
			wait_cycles(4);
			check_led($sformatf("led case %0d", i),
				led_expect(pads[i] ^ low_active_pads, outs[i], oes[i]), led);
		end
		pad_in = pads_idle;
		wait_cycles(3);
		finish_test();
	endtask

	task automatic test_unknown_addr();
		reg_data_t rd;
		int k;
		start_test("unknown address");
		bus_write(reg_out, 16'h0155);
		bus_write(reg_oe, 16'h00aa);
		bus_write(reg_irq_en, 16'h0000);
		bus_write(reg_edge, 16'h07ff);
		// dpad_u press leaves one pending bit that a stray clear would drop
		pad_in = 11'h140;
		wait_cycles(3);
		for (k = 5; k < 8; k++) begin
			bus_write(reg_addr_t'(k), 16'hffff);
		end
		bus_read(reg_irq_en, rd);
		check_data("reg_irq_en", 16'h0000, rd);
		bus_read(reg_edge, rd);
		check_data("reg_edge", 16'h0040, rd);
		bus_read(reg_oe, rd);
		check_data("reg_oe", 16'h00aa, rd);
		bus_read(reg_out, rd);
		check_data("reg_out", 16'h0155, rd);
		for (k = 5; k < 8; k++) begin
			bus_read(reg_addr_t'(k), rd);
			check_data($sformatf("read address %0d", k), 16'h0000, rd);
		end
		check_pads("pad_out", 11'h155, pad_out);
		check_pads("pad_oe", 11'h0aa, pad_oe);
		check_bit("irq", 1'b0, irq);
		finish_test();
	endtask

	initial begin
		rst_n = 1'b0;
		reg_wen = 1'b0;
		reg_ren = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		pad_in = pads_idle;
		err_count = 0;
		test_count = 0;
		tests_failed = 0;
		test_err_start = 0;
		timed_out = 1'b0;
		test_reset();
		if (!timed_out) begin
			test_output_drive();
			test_input_conditioning();
			test_edge_irq();
			test_led_mapping();
			test_unknown_addr();
		end
		$display("tests run %0d, tests failed %0d, mismatches %0d",
			test_count, tests_failed, err_count);
		if (err_count == 0 && !timed_out) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* hw/gpio_board.sv */
`timescale 1ns/10ps

module gpio_board (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,

	// processor side register access
	input  logic                                 reg_wen,
	input  logic                                 reg_ren,
	input  logic [gpio_regs_pkg::reg_addr_w-1:0] reg_addr,
	input  logic [gpio_regs_pkg::reg_data_w-1:0] reg_wdata,
	output logic [gpio_regs_pkg::reg_data_w-1:0] reg_rdata,

	// pads split into in, out and output enable
	input  logic [board_pkg::n_gpios-1:0]        pad_in,
	output logic [board_pkg::n_gpios-1:0]        pad_out,
	output logic [board_pkg::n_gpios-1:0]        pad_oe,

	output logic [board_pkg::n_leds-1:0]         led,
	output logic                                 irq
);
	import board_pkg::*;

	logic sys_rst_n;
	pad_word_u pin_level;
	pad_vec_t pin_rise;
	pad_vec_t out_reg;
	pad_vec_t oe_reg;

	board_reset board_reset_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sys_rst_n (sys_rst_n)
	);

	pad_input_sync pad_input_sync_inst (
		.clk_sys   (clk_sys),
		.sys_rst_n (sys_rst_n),
		.pad_in    (pad_in),
		.pin_level (pin_level),
		.pin_rise  (pin_rise)
	);

	gpio_regs gpio_regs_inst (
		.clk_sys   (clk_sys),
		.sys_rst_n (sys_rst_n),
		.reg_wen   (reg_wen),
		.reg_ren   (reg_ren),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.pin_level (pin_level),
		.pin_rise  (pin_rise),
		.out_reg   (out_reg),
		.oe_reg    (oe_reg),
		.irq       (irq)
	);

	pad_output pad_output_inst (
		.clk_sys   (clk_sys),
		.sys_rst_n (sys_rst_n),
		.out_reg   (out_reg),
		.oe_reg    (oe_reg),
		.pin_level (pin_level),
		.pad_out   (pad_out),
		.pad_oe    (pad_oe),
		.led       (led)
	);

endmodule

/* hw/pad_output.sv */
`timescale 1ns/10ps

module pad_output (
	input  logic                        clk_sys,
	input  logic                        sys_rst_n,
	input  board_pkg::pad_vec_t         out_reg,
	input  board_pkg::pad_vec_t         oe_reg,
	input  board_pkg::pad_word_u        pin_level,
	output board_pkg::pad_vec_t         pad_out,
	output board_pkg::pad_vec_t         pad_oe,
	output logic [board_pkg::n_leds-1:0] led
);
	import board_pkg::*;

	pad_word_u drive;
	pad_word_u drive_en;
	logic [n_leds-1:0] led_next;

	assign drive.raw = out_reg;
	assign drive_en.raw = oe_reg;

	// LEDs on the main board are active low, the snap-off ones are not
	assign led_next = {
		~drive.pins.uart_tx,
		~pin_level.pins.uart_rx,
		pin_level.pins.dpad_u,
		pin_level.pins.dpad_d,
		pin_level.pins.dpad_l,
		~pin_level.pins.dpad_r,
		~(drive.pins.led & drive_en.pins.led)
	};

	always_ff @(posedge clk_sys) begin
		if (!sys_rst_n) begin
			pad_out <= '0;
			pad_oe <= '0;
		end else begin
			pad_out <= out_reg;
			pad_oe <= oe_reg;
		end
	end

	always_ff @(posedge clk_sys) begin
		led <= led_next;
	end

endmodule

/* hw/gpio_regs.sv */
`timescale 1ns/10ps

module gpio_regs (
	input  logic                     clk_sys,
	input  logic                     sys_rst_n,

	input  logic                     reg_wen,
	input  logic                     reg_ren,
	input  gpio_regs_pkg::reg_addr_t reg_addr,
	input  gpio_regs_pkg::reg_data_t reg_wdata,
	output gpio_regs_pkg::reg_data_t reg_rdata,

	input  board_pkg::pad_word_u     pin_level,
	input  board_pkg::pad_vec_t      pin_rise,

	output board_pkg::pad_vec_t      out_reg,
	output board_pkg::pad_vec_t      oe_reg,
	output logic                     irq
);
	import board_pkg::*;
	import gpio_regs_pkg::*;

	pad_vec_t edge_pend;
	pad_vec_t irq_en;
	pad_vec_t wr_bits;
	pad_vec_t edge_clr;
	logic wr_out;
	logic wr_oe;
	logic wr_edge;
	logic wr_irq_en;
	reg_data_t rd_word;

	assign wr_bits = reg_wdata[n_gpios-1:0];

	// write decode, unknown addresses match nothing
	assign wr_out    = reg_wen && (reg_addr == reg_out);
	assign wr_oe     = reg_wen && (reg_addr == reg_oe);
	assign wr_edge   = reg_wen && (reg_addr == reg_edge);
	assign wr_irq_en = reg_wen && (reg_addr == reg_irq_en);

	assign edge_clr = wr_edge ? wr_bits : '0;

	always_comb begin
		case (reg_addr)
			reg_out:    rd_word = reg_data_t'(out_reg);
			reg_oe:     rd_word = reg_data_t'(oe_reg);
			reg_in:     rd_word = reg_data_t'(pin_level.raw);
			reg_edge:   rd_word = reg_data_t'(edge_pend);
			reg_irq_en: rd_word = reg_data_t'(irq_en);
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!sys_rst_n) begin
			out_reg <= '0;
			oe_reg <= '0;
			edge_pend <= '0;
			irq_en <= '0;
			reg_rdata <= '0;
			irq <= 1'b0;
		end else begin
			if (wr_out) begin
				out_reg <= wr_bits;
			end
			if (wr_oe) begin
				oe_reg <= wr_bits;
			end
			if (wr_irq_en) begin
				irq_en <= wr_bits;
			end
			// a new rising edge beats a clear in the same cycle
			edge_pend <= (edge_pend & ~edge_clr) | pin_rise;

			// read data holds until the next read strobe
			if (reg_ren) begin
				reg_rdata <= rd_word;
			end

			irq <= |(edge_pend & irq_en);
		end
	end

endmodule

/* hw/pad_input_sync.sv */
`timescale 1ns/10ps

module pad_input_sync (
	input  logic                 clk_sys,
	input  logic                 sys_rst_n,
	input  board_pkg::pad_vec_t  pad_in,
	output board_pkg::pad_word_u pin_level,
	output board_pkg::pad_vec_t  pin_rise
);
	import board_pkg::*;

	pad_vec_t sync_1;
	pad_vec_t sync_2;
	pad_vec_t level;
	pad_vec_t level_prev;

	// pads are asynchronous to clk_sys
	always_ff @(posedge clk_sys) begin
		if (!sys_rst_n) begin
			// idle pattern, all logical levels low
			sync_1 <= button_invert;
			sync_2 <= button_invert;
		end else begin
			sync_1 <= pad_in;
			sync_2 <= sync_1;
		end
	end

	// logical level, buttons pressed read as one
	assign level = sync_2 ^ button_invert;

	always_ff @(posedge clk_sys) begin
		if (!sys_rst_n) begin
			level_prev <= '0;
		end else begin
			level_prev <= level;
		end
	end

	assign pin_level.raw = level;

	// one cycle pulse in the cycle the new level shows up
	assign pin_rise = level & ~level_prev;

endmodule

/* hw/board_reset.sv */
`timescale 1ns/10ps

module board_reset (
	input  logic clk_sys,
	input  logic rst_n,
	output logic sys_rst_n
);
	import board_pkg::*;

	logic [1:0] rst_sync;
	logic [$clog2(reset_hold_cycles)-1:0] hold_cnt;
	logic hold_done;

	// two synchronizer stages plus the output flop are part of the hold time
	assign hold_done = rst_sync[1] &&
		(hold_cnt == ($clog2(reset_hold_cycles))'(reset_hold_cycles - 3));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rst_sync <= 2'b00;
			hold_cnt <= '0;
			sys_rst_n <= 1'b0;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
			// count only while still holding, so the counter stops
			if (rst_sync[1] && !sys_rst_n) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
			if (hold_done) begin
				sys_rst_n <= 1'b1;
			end
		end
	end

endmodule

/* hw/gpio_regs_pkg.sv */
package gpio_regs_pkg;

	localparam int reg_addr_w = 3;
	localparam int reg_data_w = 16;

	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// pad bits in the low end, upper bits read as zero
	typedef logic [reg_data_w-1:0] reg_data_t;

	// register map
	localparam reg_addr_t reg_out    = 3'd0;
	localparam reg_addr_t reg_oe     = 3'd1;
	// read only
	localparam reg_addr_t reg_in     = 3'd2;
	// write one to clear
	localparam reg_addr_t reg_edge   = 3'd3;
	localparam reg_addr_t reg_irq_en = 3'd4;

endpackage

/* hw/board_pkg.sv */
package board_pkg;

	// pads on the board connector
	localparam int n_gpios = 11;

	localparam int pin_uart_tx    = 0;
	localparam int pin_uart_rx    = 1;
	localparam int pin_flash_miso = 2;
	localparam int pin_flash_mosi = 3;
	localparam int pin_flash_sclk = 4;
	localparam int pin_flash_cs   = 5;
	localparam int pin_dpad_u     = 6;
	localparam int pin_dpad_d     = 7;
	localparam int pin_dpad_l     = 8;
	localparam int pin_dpad_r     = 9;
	localparam int pin_led        = 10;

	typedef logic [n_gpios-1:0] pad_vec_t;

	// field order follows the pin indices, msb first
	typedef struct packed {
		logic led;
		logic dpad_r;
		logic dpad_l;
		logic dpad_d;
		logic dpad_u;
		logic flash_cs;
		logic flash_sclk;
		logic flash_mosi;
		logic flash_miso;
		logic uart_rx;
		logic uart_tx;
	} pad_fields_t;

	typedef union packed {
		pad_vec_t    raw;
		pad_fields_t pins;
	} pad_word_u;

	// main board dpad_l button is wired active low
	localparam pad_vec_t button_invert = pad_vec_t'(1) << pin_dpad_l;

	// block RAMs need a settling delay after configuration
	localparam int reset_hold_cycles = 16;

	localparam int n_leds = 7;

endpackage
